// File: rtl/mgt_port_pkg.sv
// Port-level constants for the Aurora serial port control plane.
// Status bit positions describe the MAC status word read back at MAC_CTRL_STATUS.
// Only the Aurora protocol code is used by the design.
`default_nettype none

package mgt_port_pkg;

  //--------------------------------------------------
  // Port identification
  //--------------------------------------------------
  // Protocol codes as reported in port information
  typedef enum logic [7:0] {
    PROTO_DISABLED = 8'd0,
    PROTO_1GBE     = 8'd1,
    PROTO_10GBE    = 8'd2,
    PROTO_AURORA   = 8'd3
  } protocol_e;

  localparam logic [7:0] COMPAT_NUM = 8'd2;  // Bumped on register map changes

  //--------------------------------------------------
  // MAC status word layout
  //--------------------------------------------------
  localparam int MAC_ST_CHANNEL_UP = 0;
  localparam int MAC_ST_HARD_ERR   = 1;
  localparam int MAC_ST_SOFT_ERR   = 2;
  localparam int MAC_ST_LOCKED     = 3;   // BIST checker lock, not synchronized

  // Lock latency field, upper counter bits only
  localparam int MAC_ST_LAT_LO     = 4;
  localparam int MAC_ST_LAT_HI     = 19;

  localparam int MAC_ST_PRESENT    = 24;  // Always set, marks a live MAC
  localparam int MAC_ST_CRIT_ERR   = 25;  // Sticky until MAC clear

  //--------------------------------------------------
  // Lock latency counter
  //--------------------------------------------------
  localparam int LAT_WIDTH = 20;  // Wraps at this width
  localparam int LAT_DROP  = 4;   // Low bits hidden from the status word

endpackage

`default_nettype wire

// File: rtl/mgt_reg_pkg.sv
// Register map of the port control plane.
// Offsets are bytes from the register base; the base comes from the top level.
// BIST counters are wider than the bus and are read back as one 32-bit slice each.
`default_nettype none

package mgt_reg_pkg;

  //--------------------------------------------------
  // Bus geometry
  //--------------------------------------------------
  localparam int REG_DWIDTH = 32;
  localparam int REG_AWIDTH = 14;

  //--------------------------------------------------
  // Counter widths and scaling
  //--------------------------------------------------
  localparam int BIST_CNT_WIDTH = 48;
  localparam int SAMPS_SHIFT    = 16;  // Sample count is scaled by 2^16 on readback

  //--------------------------------------------------
  // Register offsets
  //--------------------------------------------------
  typedef enum logic [REG_AWIDTH-1:0] {
    PORT_INFO       = 14'h00,
    MAC_CTRL_STATUS = 14'h04,  // Write control, read status
    PHY_CTRL_STATUS = 14'h08,  // Read only here
    LED_CTL         = 14'h0C,
    // Aurora counters
    OVERRUNS        = 14'h20,
    CHECKSUM_ERRORS = 14'h24,
    BIST_SAMPS      = 14'h28,
    BIST_ERRORS     = 14'h2C
  } reg_off_e;

endpackage

`default_nettype wire

// File: rtl/mgt_status_sync.sv
// Brings the four raw PHY status bits into bus_clk.
// Each bit is synchronized on its own; bits that change together may land
// one cycle apart. SYNC_STAGES must be at least 2.
`timescale 1ns/1ps
`default_nettype none

module mgt_status_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       bus_clk,
  input  logic       bus_rst,
  input  logic [3:0] status_raw_i,   // {crit_err, soft_err, hard_err, channel_up}
  output logic [3:0] status_sync_o
);

  //--------------------------------------------------
  // Flop chain
  //--------------------------------------------------
  logic [3:0] stage [SYNC_STAGES];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= status_raw_i;  // First stage may go metastable
      for (int i = 1; i < SYNC_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign status_sync_o = stage[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: rtl/link_health_monitor.sv
// Tracks BIST lock latency and latches MAC critical errors.
// status_sync_i must already be in bus_clk; the checker lock bit is used as is.
// Status words are combinational from registered state.
`timescale 1ns/1ps
`default_nettype none

module link_health_monitor (
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic [3:0]  status_sync_i,   // {crit_err, soft_err, hard_err, channel_up}
  input  logic        bist_checker_locked_i,
  input  logic        bist_checker_en_i,
  input  logic        mac_clear_i,
  output logic [31:0] mac_status_o,
  output logic [31:0] phy_status_o
);

  logic                             channel_up;
  logic                             hard_err;
  logic                             soft_err;
  logic                             crit_err;
  logic [mgt_port_pkg::LAT_WIDTH-1:0] lock_lat;
  logic                             crit_latch;

  assign channel_up = status_sync_i[0];
  assign hard_err   = status_sync_i[1];
  assign soft_err   = status_sync_i[2];
  assign crit_err   = status_sync_i[3];

  //--------------------------------------------------
  // Lock latency and error latch
  //--------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_lat <= '0;
    end else if (!bist_checker_locked_i) begin
      if (bist_checker_en_i)
        lock_lat <= lock_lat + 1'b1;  // Wraps, no saturation
      else
        lock_lat <= '0;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst || mac_clear_i) begin
      crit_latch <= 1'b0;  // Clear wins over a new error
    end else if (crit_err) begin
      crit_latch <= 1'b1;
    end
  end

  //--------------------------------------------------
  // Status word assembly
  //--------------------------------------------------
  always_comb begin
    mac_status_o = '0;
    mac_status_o[mgt_port_pkg::MAC_ST_CHANNEL_UP] = channel_up;
    mac_status_o[mgt_port_pkg::MAC_ST_HARD_ERR]   = hard_err;
    mac_status_o[mgt_port_pkg::MAC_ST_SOFT_ERR]   = soft_err;
    mac_status_o[mgt_port_pkg::MAC_ST_LOCKED]     = bist_checker_locked_i;
    mac_status_o[mgt_port_pkg::MAC_ST_LAT_HI:mgt_port_pkg::MAC_ST_LAT_LO] =
      lock_lat[mgt_port_pkg::LAT_WIDTH-1:mgt_port_pkg::LAT_DROP];
    mac_status_o[mgt_port_pkg::MAC_ST_PRESENT]    = 1'b1;
    mac_status_o[mgt_port_pkg::MAC_ST_CRIT_ERR]   = crit_latch;
  end

  assign phy_status_o = {30'd0, hard_err, channel_up};

endmodule

`default_nettype wire

// File: rtl/mgt_regport.sv
// Register block of the port: write decode, control registers, read mux.
// A read of an unknown address gets no response at all, and the master must
// not issue a read in the cycle a response appears. Writes are not acknowledged.
`timescale 1ns/1ps
`default_nettype none

module mgt_regport #(
  parameter logic [mgt_reg_pkg::REG_AWIDTH-1:0] REG_BASE = '0,
  parameter logic [7:0]                         PORTNUM  = 8'd0
) (
  input  logic                                   bus_clk,
  input  logic                                   bus_rst,
  // Register port
  input  logic                                   reg_wr_req_i,
  input  logic [mgt_reg_pkg::REG_AWIDTH-1:0]     reg_wr_addr_i,
  input  logic [mgt_reg_pkg::REG_DWIDTH-1:0]     reg_wr_data_i,
  input  logic                                   reg_rd_req_i,
  input  logic [mgt_reg_pkg::REG_AWIDTH-1:0]     reg_rd_addr_i,
  output logic                                   reg_rd_resp_o,
  output logic [mgt_reg_pkg::REG_DWIDTH-1:0]     reg_rd_data_o,
  // Readback sources
  input  logic [31:0]                            mac_status_i,
  input  logic [31:0]                            phy_status_i,
  input  logic                                   link_up_i,
  input  logic                                   activity_i,
  input  logic [31:0]                            overruns_i,
  input  logic [31:0]                            checksum_errors_i,
  input  logic [mgt_reg_pkg::BIST_CNT_WIDTH-1:0] bist_samps_i,
  input  logic [mgt_reg_pkg::BIST_CNT_WIDTH-1:0] bist_errors_i,
  // Controls
  output logic [31:0]                            mac_ctrl_o,
  output logic                                   identify_en_o,
  output logic                                   identify_val_o
);

  logic [mgt_reg_pkg::REG_AWIDTH-1:0] wr_off;
  logic [mgt_reg_pkg::REG_AWIDTH-1:0] rd_off;
  logic [31:0]                        mac_ctrl;
  logic [1:0]                         led_ctl;   // {identify value, identify enable}
  logic [31:0]                        port_info;
  logic [mgt_reg_pkg::REG_DWIDTH-1:0] rd_mux;
  logic                               rd_hit;

  // Offsets relative to the base, compared against the register map
  assign wr_off = reg_wr_addr_i - REG_BASE;
  assign rd_off = reg_rd_addr_i - REG_BASE;

  //--------------------------------------------------
  // Writable registers
  //--------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      mac_ctrl <= '0;
      led_ctl  <= '0;
    end else if (reg_wr_req_i) begin
      case (wr_off)
        mgt_reg_pkg::MAC_CTRL_STATUS: mac_ctrl <= reg_wr_data_i;
        mgt_reg_pkg::LED_CTL:         led_ctl  <= reg_wr_data_i[1:0];
        default: ;  // PHY control and read-only offsets drop the write
      endcase
    end
  end

  assign mac_ctrl_o     = mac_ctrl;
  assign identify_en_o  = led_ctl[0];
  assign identify_val_o = led_ctl[1];

  //--------------------------------------------------
  // Readback
  //--------------------------------------------------
  assign port_info = {mgt_port_pkg::COMPAT_NUM, 6'h0, activity_i, link_up_i,
                      mgt_port_pkg::PROTO_AURORA, PORTNUM};

  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    case (rd_off)
      mgt_reg_pkg::PORT_INFO:       rd_mux = port_info;
      mgt_reg_pkg::MAC_CTRL_STATUS: rd_mux = mac_status_i;   // Status, not the control value
      mgt_reg_pkg::PHY_CTRL_STATUS: rd_mux = phy_status_i;
      mgt_reg_pkg::LED_CTL:         rd_mux = {30'd0, led_ctl};
      mgt_reg_pkg::OVERRUNS:        rd_mux = overruns_i;
      mgt_reg_pkg::CHECKSUM_ERRORS: rd_mux = checksum_errors_i;
      mgt_reg_pkg::BIST_SAMPS:
        rd_mux = bist_samps_i[mgt_reg_pkg::SAMPS_SHIFT +: mgt_reg_pkg::REG_DWIDTH];
      mgt_reg_pkg::BIST_ERRORS:
        rd_mux = bist_errors_i[mgt_reg_pkg::REG_DWIDTH-1:0];  // Unscaled
      default:                      rd_hit = 1'b0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst)
      reg_rd_resp_o <= 1'b0;
    else
      reg_rd_resp_o <= reg_rd_req_i && rd_hit;  // One cycle per request
  end

  always_ff @(posedge bus_clk) begin
    if (reg_rd_req_i)
      reg_rd_data_o <= rd_mux;
  end

endmodule

`default_nettype wire

// File: rtl/activity_led.sv
// Activity LED driver: stretches stream handshakes into a visible pulse.
// The stretcher is held off while the link is down; the identify override
// still applies then. Output lags the stretcher by one register.
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
  parameter int STRETCH_CYCLES = 16
) (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic link_up_i,
  input  logic tx_valid_i,
  input  logic tx_ready_i,
  input  logic rx_valid_i,
  input  logic rx_ready_i,
  input  logic identify_en_i,
  input  logic identify_val_i,
  output logic activity_o
);

  localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

  typedef enum logic {IDLE, STRETCH} state_e;

  state_e           state;
  logic [CNT_W-1:0] hold_cnt;
  logic             beat;
  logic             stretched;

  assign beat = (tx_valid_i && tx_ready_i) || (rx_valid_i && rx_ready_i);

  //--------------------------------------------------
  // Pulse stretcher
  //--------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst || !link_up_i) begin
      state    <= IDLE;
      hold_cnt <= '0;
    end else if (beat) begin
      state    <= STRETCH;                     // Any beat restarts the hold
      hold_cnt <= CNT_W'(STRETCH_CYCLES - 1);
    end else if (state == STRETCH) begin
      if (hold_cnt == '0)
        state <= IDLE;
      else
        hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign stretched = (state == STRETCH);

  // Identify override
  always_ff @(posedge bus_clk) begin
    if (bus_rst)
      activity_o <= 1'b0;
    else
      activity_o <= identify_en_i ? identify_val_i : stretched;
  end

endmodule

`default_nettype wire

// File: rtl/mgt_ctrl_core.sv
// Bus-clock control plane of one Aurora port. PHY and MAC cores live outside;
// their raw status bits may come from another clock, all other inputs are in bus_clk.
// SYNC_STAGES must be at least 2.
`timescale 1ns/1ps
`default_nettype none

module mgt_ctrl_core #(
  parameter logic [mgt_reg_pkg::REG_AWIDTH-1:0] REG_BASE       = '0,
  parameter logic [7:0]                         PORTNUM        = 8'd0,
  parameter int                                 SYNC_STAGES    = 2,
  parameter int                                 STRETCH_CYCLES = 16
) (
  input  logic                                   bus_clk,
  input  logic                                   bus_rst,
  // Raw PHY and MAC status
  input  logic                                   channel_up_i,
  input  logic                                   hard_err_i,
  input  logic                                   soft_err_i,
  input  logic                                   mac_crit_err_i,
  input  logic                                   bist_checker_locked_i,
  // MAC counters
  input  logic [31:0]                            overruns_i,
  input  logic [31:0]                            checksum_errors_i,
  input  logic [mgt_reg_pkg::BIST_CNT_WIDTH-1:0] bist_samps_i,
  input  logic [mgt_reg_pkg::BIST_CNT_WIDTH-1:0] bist_errors_i,
  // Stream handshakes
  input  logic                                   tx_valid_i,
  input  logic                                   tx_ready_i,
  input  logic                                   rx_valid_i,
  input  logic                                   rx_ready_i,
  // Register port
  input  logic                                   reg_wr_req_i,
  input  logic [mgt_reg_pkg::REG_AWIDTH-1:0]     reg_wr_addr_i,
  input  logic [mgt_reg_pkg::REG_DWIDTH-1:0]     reg_wr_data_i,
  input  logic                                   reg_rd_req_i,
  input  logic [mgt_reg_pkg::REG_AWIDTH-1:0]     reg_rd_addr_i,
  output logic                                   reg_rd_resp_o,
  output logic [mgt_reg_pkg::REG_DWIDTH-1:0]     reg_rd_data_o,
  // Status and controls
  output logic                                   link_up_o,
  output logic                                   activity_o,
  output logic                                   bist_checker_en_o,
  output logic                                   bist_gen_en_o,
  output logic                                   bist_loopback_en_o,
  output logic [5:0]                             bist_gen_rate_o,
  output logic                                   phy_areset_o,
  output logic                                   mac_clear_o
);

  logic [3:0]  status_sync;
  logic [31:0] mac_status;
  logic [31:0] phy_status;
  logic [31:0] mac_ctrl;
  logic        identify_en;
  logic        identify_val;

  //--------------------------------------------------
  // Input side
  //--------------------------------------------------
  mgt_status_sync #(.SYNC_STAGES(SYNC_STAGES)) u_status_sync (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .status_raw_i  ({mac_crit_err_i, soft_err_i, hard_err_i, channel_up_i}),
    .status_sync_o (status_sync)
  );

  assign link_up_o = status_sync[0];

  //--------------------------------------------------
  // Processing
  //--------------------------------------------------
  link_health_monitor u_health (
    .bus_clk               (bus_clk),
    .bus_rst               (bus_rst),
    .status_sync_i         (status_sync),
    .bist_checker_locked_i (bist_checker_locked_i),
    .bist_checker_en_i     (bist_checker_en_o),
    .mac_clear_i           (mac_clear_o),
    .mac_status_o          (mac_status),
    .phy_status_o          (phy_status)
  );

  mgt_regport #(.REG_BASE(REG_BASE), .PORTNUM(PORTNUM)) u_regport (
    .bus_clk           (bus_clk),
    .bus_rst           (bus_rst),
    .reg_wr_req_i      (reg_wr_req_i),
    .reg_wr_addr_i     (reg_wr_addr_i),
    .reg_wr_data_i     (reg_wr_data_i),
    .reg_rd_req_i      (reg_rd_req_i),
    .reg_rd_addr_i     (reg_rd_addr_i),
    .reg_rd_resp_o     (reg_rd_resp_o),
    .reg_rd_data_o     (reg_rd_data_o),
    .mac_status_i      (mac_status),
    .phy_status_i      (phy_status),
    .link_up_i         (link_up_o),
    .activity_i        (activity_o),
    .overruns_i        (overruns_i),
    .checksum_errors_i (checksum_errors_i),
    .bist_samps_i      (bist_samps_i),
    .bist_errors_i     (bist_errors_i),
    .mac_ctrl_o        (mac_ctrl),
    .identify_en_o     (identify_en),
    .identify_val_o    (identify_val)
  );

  // MAC control register fields
  assign bist_checker_en_o  = mac_ctrl[0];
  assign bist_gen_en_o      = mac_ctrl[1];
  assign bist_loopback_en_o = mac_ctrl[2];
  assign bist_gen_rate_o    = mac_ctrl[8:3];
  assign phy_areset_o       = mac_ctrl[9];
  assign mac_clear_o        = mac_ctrl[10];

  //--------------------------------------------------
  // Output side
  //--------------------------------------------------
  activity_led #(.STRETCH_CYCLES(STRETCH_CYCLES)) u_activity_led (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .link_up_i      (link_up_o),
    .tx_valid_i     (tx_valid_i),
    .tx_ready_i     (tx_ready_i),
    .rx_valid_i     (rx_valid_i),
    .rx_ready_i     (rx_ready_i),
    .identify_en_i  (identify_en),
    .identify_val_i (identify_val),
    .activity_o     (activity_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_reg_vectors.svh
// Register vectors for the table-driven test, included inside the testbench module.
// Uses TB_PORTNUM from the including module. Offsets are bytes from the base.
`ifndef TB_REG_VECTORS_SVH
`define TB_REG_VECTORS_SVH

localparam int NUM_REG_VECS = 12;
localparam int VEC_WIDTH    = 80;

// Compat 2, six zeros, activity 0, link 0, protocol 3, port number
localparam logic [31:0] EXP_PORT_INFO = {8'd2, 6'd0, 1'b0, 1'b0, 8'd3, TB_PORTNUM};

// Entry is {write, expect response, offset, write data, expected read data}
function automatic logic [VEC_WIDTH-1:0] reg_vector(input int idx);
  case (idx)
    //               wr    resp  offset  write data     expected
    0:  reg_vector = {1'b0, 1'b1, 14'h00, 32'h0000_0000, EXP_PORT_INFO};
    1:  reg_vector = {1'b1, 1'b0, 14'h04, 32'h0000_05AE, 32'h0000_0000};
    2:  reg_vector = {1'b1, 1'b0, 14'h0C, 32'hFFFF_FFFE, 32'h0000_0000};
    3:  reg_vector = {1'b0, 1'b1, 14'h0C, 32'h0000_0000, 32'h0000_0002};
    4:  reg_vector = {1'b1, 1'b0, 14'h08, 32'hFFFF_FFFF, 32'h0000_0000};  // Dropped
    5:  reg_vector = {1'b0, 1'b1, 14'h08, 32'h0000_0000, 32'h0000_0000};  // Link down
    6:  reg_vector = {1'b0, 1'b1, 14'h0C, 32'h0000_0000, 32'h0000_0002};
    7:  reg_vector = {1'b0, 1'b0, 14'h10, 32'h0000_0000, 32'h0000_0000};  // Unmapped
    8:  reg_vector = {1'b0, 1'b0, 14'h30, 32'h0000_0000, 32'h0000_0000};
    9:  reg_vector = {1'b1, 1'b0, 14'h0C, 32'h0000_0000, 32'h0000_0000};
    10: reg_vector = {1'b0, 1'b1, 14'h0C, 32'h0000_0000, 32'h0000_0000};
    11: reg_vector = {1'b1, 1'b0, 14'h04, 32'h0000_0251, 32'h0000_0000};  // Complement of 0x5AE
    default: reg_vector = '0;
  endcase
endfunction

`endif

// File: verif/tb_mgt_ctrl_core.sv
// Testbench for the port control plane. Inputs change on the rising edge,
// outputs are sampled on the falling edge. Raw status bits are driven in bus_clk.
`timescale 1ns/1ps
`default_nettype none

module tb_mgt_ctrl_core;

  localparam logic [13:0] TB_REG_BASE  = 14'h0400;
  localparam logic [7:0]  TB_PORTNUM   = 8'h5A;
  localparam int          TB_SYNC      = 2;
  localparam int          TB_STRETCH   = 16;
  localparam int          RESP_TIMEOUT = 10;
  localparam int          LOCK_HOLD    = 32 * 16;

  logic        bus_clk;
  logic        bus_rst;
  logic        channel_up;
  logic        hard_err;
  logic        soft_err;
  logic        crit_err;
  logic        locked;
  logic [31:0] overruns;
  logic [31:0] cksum_errs;
  logic [47:0] samps;
  logic [47:0] bist_errs;
  logic        tx_valid;
  logic        tx_ready;
  logic        rx_valid;
  logic        rx_ready;
  logic        wr_req;
  logic [13:0] wr_addr;
  logic [31:0] wr_data;
  logic        rd_req;
  logic [13:0] rd_addr;
  logic        rd_resp;
  logic [31:0] rd_data;
  logic        link_up;
  logic        activity;
  logic        checker_en;
  logic        gen_en;
  logic        loopback_en;
  logic [5:0]  gen_rate;
  logic        phy_areset;
  logic        mac_clear;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          start_err;
  int          wait_n;
  logic        got;
  logic        seen;
  logic [31:0] data;
  int          lat;
  logic [79:0] vec;
  logic [31:0] exp_ctrl;
  logic [31:0] rnd_hi;
  logic [47:0] rnd_samps;
  logic [47:0] rnd_errs;
  logic [31:0] rnd_ovr;
  logic [31:0] rnd_cks;

  `include "tb_reg_vectors.svh"

  mgt_ctrl_core #(
    .REG_BASE       (TB_REG_BASE),
    .PORTNUM        (TB_PORTNUM),
    .SYNC_STAGES    (TB_SYNC),
    .STRETCH_CYCLES (TB_STRETCH)
  ) DUT (
    .bus_clk               (bus_clk),
    .bus_rst               (bus_rst),
    .channel_up_i          (channel_up),
    .hard_err_i            (hard_err),
    .soft_err_i            (soft_err),
    .mac_crit_err_i        (crit_err),
    .bist_checker_locked_i (locked),
    .overruns_i            (overruns),
    .checksum_errors_i     (cksum_errs),
    .bist_samps_i          (samps),
    .bist_errors_i         (bist_errs),
    .tx_valid_i            (tx_valid),
    .tx_ready_i            (tx_ready),
    .rx_valid_i            (rx_valid),
    .rx_ready_i            (rx_ready),
    .reg_wr_req_i          (wr_req),
    .reg_wr_addr_i         (wr_addr),
    .reg_wr_data_i         (wr_data),
    .reg_rd_req_i          (rd_req),
    .reg_rd_addr_i         (rd_addr),
    .reg_rd_resp_o         (rd_resp),
    .reg_rd_data_o         (rd_data),
    .link_up_o             (link_up),
    .activity_o            (activity),
    .bist_checker_en_o     (checker_en),
    .bist_gen_en_o         (gen_en),
    .bist_loopback_en_o    (loopback_en),
    .bist_gen_rate_o       (gen_rate),
    .phy_areset_o          (phy_areset),
    .mac_clear_o           (mac_clear)
  );

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;  // 8 ns period
  end

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic check_word(input string what, input logic [31:0] got_w,
                            input logic [31:0] exp_w);
    if (got_w !== exp_w)
      report_mismatch($sformatf("%s read %08h, expected %08h", what, got_w, exp_w));
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_start);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  // --------------------------------------------------
  // Register port
  // --------------------------------------------------
  task automatic reg_write(input logic [13:0] off, input logic [31:0] wdata);
    @(posedge bus_clk);
    wr_req  <= 1'b1;
    wr_addr <= TB_REG_BASE + off;
    wr_data <= wdata;
    @(posedge bus_clk);
    wr_req  <= 1'b0;
  endtask

  task automatic reg_read(input logic [13:0] off, output logic resp,
                          output logic [31:0] rdata, output int cycles);
    int n;
    resp   = 1'b0;
    rdata  = '0;
    cycles = 0;
    n      = 0;
    @(posedge bus_clk);
    rd_req  <= 1'b1;
    rd_addr <= TB_REG_BASE + off;
    @(posedge bus_clk);
    rd_req  <= 1'b0;
    while (!resp && n < RESP_TIMEOUT) begin
      @(negedge bus_clk);
      n++;
      if (rd_resp) begin
        resp   = 1'b1;
        rdata  = rd_data;
        cycles = n;
      end
    end
    if (resp) begin
      @(negedge bus_clk);
      if (rd_resp)
        report_problem("read response stayed high for more than one cycle");
    end
  endtask

  task automatic read_expect(input string what, input logic [13:0] off,
                             input logic [31:0] exp_w);
    logic        resp;
    logic [31:0] rdata;
    int          cycles;
    reg_read(off, resp, rdata, cycles);
    if (!resp)
      report_problem({"no read response for ", what});
    else if (cycles != 1)
      report_problem($sformatf("%s answered after %0d cycles instead of 1", what, cycles));
    else
      check_word(what, rdata, exp_w);
  endtask

  // Field map of the MAC control register
  task automatic check_controls(input logic [31:0] exp_w);
    logic [10:0] ctl;
    ctl = {mac_clear, phy_areset, gen_rate, loopback_en, gen_en, checker_en};
    if (ctl !== exp_w[10:0])
      report_mismatch($sformatf("control outputs %03h, expected %03h", ctl, exp_w[10:0]));
  endtask

  task automatic drive_beat(input logic on_tx);
    @(posedge bus_clk);
    if (on_tx) begin
      tx_valid <= 1'b1;
      tx_ready <= 1'b1;
    end else begin
      rx_valid <= 1'b1;
      rx_ready <= 1'b1;
    end
    @(posedge bus_clk);
    tx_valid <= 1'b0;
    tx_ready <= 1'b0;
    rx_valid <= 1'b0;
    rx_ready <= 1'b0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    bus_rst      = 1'b1;
    channel_up   = 1'b0;
    hard_err     = 1'b0;
    soft_err     = 1'b0;
    crit_err     = 1'b0;
    locked       = 1'b0;
    overruns     = '0;
    cksum_errs   = '0;
    samps        = '0;
    bist_errs    = '0;
    tx_valid     = 1'b0;
    tx_ready     = 1'b0;
    rx_valid     = 1'b0;
    rx_ready     = 1'b0;
    wr_req       = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    rd_req       = 1'b0;
    rd_addr      = '0;
    void'($urandom(32'h92a1_a0f4));

    repeat (5) @(posedge bus_clk);
    bus_rst <= 1'b0;

    // Reset values
    start_err = errors;
    @(negedge bus_clk);
    check_controls(32'h0);
    if (activity !== 1'b0)
      report_mismatch("activity_o high after reset");
    read_expect("PORT_INFO", 14'h00, EXP_PORT_INFO);
    end_test("reset and port information", start_err);

    // Vector table, control outputs checked after every write
    start_err = errors;
    exp_ctrl  = '0;
    for (int i = 0; i < NUM_REG_VECS; i++) begin
      vec = reg_vector(i);
      if (vec[79]) begin
        reg_write(vec[77:64], vec[63:32]);
        if (vec[77:64] == 14'h04)
          exp_ctrl = vec[63:32];
        @(negedge bus_clk);
        check_controls(exp_ctrl);
      end else begin
        reg_read(vec[77:64], got, data, lat);
        if (vec[78] && !got)
          report_problem($sformatf("vector %0d got no read response", i));
        else if (!vec[78] && got)
          report_problem($sformatf("vector %0d got a response for an unmapped offset", i));
        else if (got && lat != 1)
          report_problem($sformatf("vector %0d answered after %0d cycles", i, lat));
        else if (got)
          check_word($sformatf("vector %0d", i), data, vec[31:0]);
      end
    end
    reg_write(14'h04, 32'h0);
    end_test("register vector table", start_err);

    // Counter readback with random inputs
    start_err = errors;
    for (int r = 0; r < 4; r++) begin
      rnd_ovr   = $urandom;
      rnd_cks   = $urandom;
      rnd_hi    = $urandom;
      rnd_samps = {rnd_hi[15:0], $urandom};
      rnd_hi    = $urandom;
      rnd_errs  = {rnd_hi[15:0], $urandom};
      @(posedge bus_clk);
      overruns   <= rnd_ovr;
      cksum_errs <= rnd_cks;
      samps      <= rnd_samps;
      bist_errs  <= rnd_errs;
      read_expect("OVERRUNS", 14'h20, rnd_ovr);
      read_expect("CHECKSUM_ERRORS", 14'h24, rnd_cks);
      read_expect("BIST_SAMPS", 14'h28, rnd_samps[47:16]);  // Scaled by 2^16
      read_expect("BIST_ERRORS", 14'h2C, rnd_errs[31:0]);
    end
    end_test("counter readback", start_err);

    // Status sync and critical error latch
    start_err = errors;
    @(posedge bus_clk);
    channel_up <= 1'b1;
    hard_err   <= 1'b1;
    wait_n = 0;
    while (link_up !== 1'b1 && wait_n < RESP_TIMEOUT) begin
      @(negedge bus_clk);
      wait_n++;
    end
    if (link_up !== 1'b1)
      report_problem("link_up_o did not rise within 10 cycles");
    read_expect("PHY_CTRL_STATUS", 14'h08, 32'h0000_0003);
    read_expect("MAC_CTRL_STATUS", 14'h04, 32'h0100_0003);
    @(posedge bus_clk);
    crit_err <= 1'b1;
    @(posedge bus_clk);
    crit_err <= 1'b0;
    seen   = 1'b0;
    wait_n = 0;
    while (!seen && wait_n < RESP_TIMEOUT) begin
      reg_read(14'h04, got, data, lat);
      wait_n++;
      if (got && data[25])
        seen = 1'b1;
    end
    if (!seen)
      report_problem("critical error bit did not set after the error pulse");
    read_expect("MAC status with latched error", 14'h04, 32'h0300_0003);
    reg_write(14'h04, 32'h0000_0400);
    @(negedge bus_clk);
    check_controls(32'h0000_0400);
    read_expect("MAC status after clear", 14'h04, 32'h0100_0003);
    reg_write(14'h04, 32'h0);
    read_expect("MAC status after release", 14'h04, 32'h0100_0003);
    end_test("status sync and error latch", start_err);

    // Lock latency, upper 16 counter bits shown
    start_err = errors;
    reg_write(14'h04, 32'h0000_0001);
    for (int c = 0; c < LOCK_HOLD; c++)
      @(posedge bus_clk);
    locked <= 1'b1;
    reg_read(14'h04, got, data, lat);
    if (!got) begin
      report_problem("no read response for the latency check");
    end else begin
      if (data[19:4] < 16'd31 || data[19:4] > 16'd33)
        report_mismatch($sformatf("latency field %0d, expected 32 +-1", data[19:4]));
      if (data[3] !== 1'b1)
        report_mismatch("lock bit clear in MAC status");
    end
    @(posedge bus_clk);
    locked <= 1'b0;
    reg_write(14'h04, 32'h0);
    end_test("lock latency", start_err);

    // Activity LED
    start_err = errors;
    drive_beat(1'b1);
    wait_n = 0;
    while (activity !== 1'b1 && wait_n < RESP_TIMEOUT) begin
      @(negedge bus_clk);
      wait_n++;
    end
    if (activity !== 1'b1)
      report_problem("activity_o did not rise after a stream beat");
    while (activity !== 1'b0 && wait_n < TB_STRETCH + 4) begin
      @(negedge bus_clk);
      wait_n++;
    end
    if (activity !== 1'b0)
      report_problem("activity_o still high long after the last beat");
    reg_write(14'h0C, 32'h0000_0003);  // Identify on, value 1
    wait_n = 0;
    while (activity !== 1'b1 && wait_n < RESP_TIMEOUT) begin
      @(negedge bus_clk);
      wait_n++;
    end
    if (activity !== 1'b1)
      report_problem("identify override did not drive activity_o high");
    reg_write(14'h0C, 32'h0);
    @(posedge bus_clk);
    channel_up <= 1'b0;
    wait_n = 0;
    while (link_up !== 1'b0 && wait_n < RESP_TIMEOUT) begin
      @(negedge bus_clk);
      wait_n++;
    end
    if (link_up !== 1'b0)
      report_problem("link_up_o did not fall within 10 cycles");
    drive_beat(1'b0);
    seen = 1'b0;
    for (int c = 0; c < TB_STRETCH + 4; c++) begin
      @(negedge bus_clk);
      if (activity !== 1'b0)
        seen = 1'b1;
    end
    if (seen)
      report_mismatch("activity_o rose on a beat while the link was down");
    end_test("activity LED", start_err);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
rtl/mgt_port_pkg.sv
rtl/mgt_reg_pkg.sv
rtl/mgt_status_sync.sv
rtl/link_health_monitor.sv
rtl/mgt_regport.sv
rtl/activity_led.sv
rtl/mgt_ctrl_core.sv
verif/tb_mgt_ctrl_core.sv

// File: Bender.yml
package:
  name: mgt_ctrl_core

sources:
  - files:
      - rtl/mgt_port_pkg.sv
      - rtl/mgt_reg_pkg.sv
      - rtl/mgt_status_sync.sv
      - rtl/link_health_monitor.sv
      - rtl/mgt_regport.sv
      - rtl/activity_led.sv
      - rtl/mgt_ctrl_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_mgt_ctrl_core.sv
